/* Makefile */
# Verilator build and run of the SD command path testbench

TOP := sd_cmd_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sd_cmd_host.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* hdl/sd_cmd_crc7.sv */
////////////////////////////////////////////////////////////////////////////
// Serial CRC7 of the SD CMD line, one bit per enabled cycle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sd_cmd_crc7 (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          clear,
   input  logic                          shift_en,
   input  logic                          bit_in,
   output logic [sd_cmd_pkg::crc_bits-1:0] crc
);

   import sd_cmd_pkg::*;

   logic feedback;

   // Incoming bit against the top of the register
   assign feedback = bit_in ^ crc[crc_bits-1];

   // Feeding the top bit back in shifts the register out unchanged
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         crc <= '0;
      end else if (clear) begin
         crc <= '0;
      end else if (shift_en) begin
         crc <= {crc[crc_bits-2:0], 1'b0} ^ (feedback ? crc7_poly : '0);
      end
   end

endmodule

/* hdl/sd_cmd_host.sv */
////////////////////////////////////////////////////////////////////////////
// SD host command path, top level
// Register file, CMD transmitter and CMD receiver
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sd_cmd_host (
   input  logic        clk,
   input  logic        rst_n,
   // Processor register port
   input  logic [11:0] reg_address,
   input  logic [31:0] reg_wr_data,
   input  logic        reg_wr_en,
   output logic [31:0] reg_rd_data,
   // CMD line, the pad tristate sits outside
   input  logic        cmd_in,
   output logic        cmd_out,
   output logic        cmd_oe,
   // One cycle per finished command
   output logic        cmd_done
);

   import sd_cmd_pkg::*;

   logic     launch;
   sd_cmd_t  cmd;
   logic     tx_done;
   logic     resp_expected;
   logic     result_valid;
   sd_resp_t result;

   sd_cmd_regs u_regs (
      .clk          (clk),
      .rst_n        (rst_n),
      .reg_address  (reg_address),
      .reg_wr_data  (reg_wr_data),
      .reg_wr_en    (reg_wr_en),
      .reg_rd_data  (reg_rd_data),
      .launch       (launch),
      .cmd          (cmd),
      .result_valid (result_valid),
      .result       (result),
      .cmd_done     (cmd_done)
   );

   sd_cmd_tx u_tx (
      .clk           (clk),
      .rst_n         (rst_n),
      .launch        (launch),
      .cmd           (cmd),
      .cmd_out       (cmd_out),
      .cmd_oe        (cmd_oe),
      .tx_done       (tx_done),
      .resp_expected (resp_expected)
   );

   sd_cmd_rx u_rx (
      .clk           (clk),
      .rst_n         (rst_n),
      .tx_done       (tx_done),
      .resp_expected (resp_expected),
      .cmd_in        (cmd_in),
      .result_valid  (result_valid),
      .result        (result)
   );

endmodule

/* hdl/sd_cmd_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared definitions of the SD command path
// Register map, CMD frame constants, launched command and result structs
////////////////////////////////////////////////////////////////////////////

package sd_cmd_pkg;

   ////////////////////////////////////////////////////////////////////////
   // Register map of the processor port
   ////////////////////////////////////////////////////////////////////////

   // Argument halves, loaded before the command word
   localparam logic [11:0] addr_arg_lo   = 12'h008;
   localparam logic [11:0] addr_arg_hi   = 12'h00A;
   // Writing the command word starts a transaction
   localparam logic [11:0] addr_cmd      = 12'h00E;
   // Result side, read only
   localparam logic [11:0] addr_resp_lo  = 12'h010;
   localparam logic [11:0] addr_resp_hi  = 12'h012;
   localparam logic [11:0] addr_status   = 12'h014;

   // Response type field of the command word, bits 9 to 8
   localparam logic [1:0]  resp_r48      = 2'd1;

   ////////////////////////////////////////////////////////////////////////
   // CMD line framing
   ////////////////////////////////////////////////////////////////////////

   localparam int frame_bits  = 48;
   // Start, transmission bit, index and argument are covered by the CRC
   localparam int head_bits   = 40;
   localparam int crc_bits    = 7;
   // Cycles the host listens for the response start bit
   localparam int ncr_max     = 64;
   localparam int frame_cnt_w = $clog2(frame_bits);
   localparam int ncr_cnt_w   = $clog2(ncr_max);

   // x^7 + x^3 + 1, top term implicit
   localparam logic [crc_bits-1:0] crc7_poly = 7'h09;

   // One launched command
   typedef struct packed {
      logic [5:0]  index;
      logic [31:0] argument;
      logic        resp_expected;
   } sd_cmd_t;

   // One finished command
   typedef struct packed {
      logic [5:0]  index;
      logic [31:0] payload;
      logic        crc_err;
      logic        end_err;
      logic        timeout;
   } sd_resp_t;

endpackage

/* hdl/sd_cmd_regs.sv */
////////////////////////////////////////////////////////////////////////////
// Register file of the SD command path
// Argument and command registers, command launch, busy flag,
// result storage, read multiplexer and completion pulse
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sd_cmd_regs (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [11:0]          reg_address,
   input  logic [31:0]          reg_wr_data,
   input  logic                 reg_wr_en,
   output logic [31:0]          reg_rd_data,
   output logic                 launch,
   output sd_cmd_pkg::sd_cmd_t  cmd,
   input  logic                 result_valid,
   input  sd_cmd_pkg::sd_resp_t result,
   output logic                 cmd_done
);

   import sd_cmd_pkg::*;

   logic [15:0] arg_lo;
   logic [15:0] arg_hi;
   logic [5:0]  cmd_index;
   logic [1:0]  cmd_resp_type;
   logic [31:0] resp_payload;
   logic [5:0]  resp_index;
   logic        busy;
   logic        crc_err;
   logic        end_err;
   logic        timeout;
   logic        cmd_wr;
   logic        cmd_accept;

   // Command write, only taken while idle
   assign cmd_wr     = reg_wr_en && (reg_address == addr_cmd);
   assign cmd_accept = cmd_wr && !busy;

   ////////////////////////////////////////////////////////////////////////
   // Data registers
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reg_wr_en && (reg_address == addr_arg_lo)) begin
         arg_lo <= reg_wr_data[15:0];
      end
      if (reg_wr_en && (reg_address == addr_arg_hi)) begin
         arg_hi <= reg_wr_data[15:0];
      end
      // Index in bits 5:0, response type in bits 9:8
      if (cmd_accept) begin
         cmd_index     <= reg_wr_data[5:0];
         cmd_resp_type <= reg_wr_data[9:8];
      end
      if (result_valid) begin
         resp_payload <= result.payload;
         resp_index   <= result.index;
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // Launch, busy and status flags
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         launch   <= 1'b0;
         busy     <= 1'b0;
         cmd_done <= 1'b0;
         crc_err  <= 1'b0;
         end_err  <= 1'b0;
         timeout  <= 1'b0;
      end else begin
         // Launch strobe one cycle after the accepted write
         launch   <= cmd_accept;
         cmd_done <= result_valid;
         if (cmd_accept) begin
            busy    <= 1'b1;
            // Flags of the previous command go away on a new launch
            crc_err <= 1'b0;
            end_err <= 1'b0;
            timeout <= 1'b0;
         end else if (result_valid) begin
            busy    <= 1'b0;
            crc_err <= result.crc_err;
            end_err <= result.end_err;
            timeout <= result.timeout;
         end
      end
   end

   // Command as seen by the transmitter
   always_comb begin
      cmd.index         = cmd_index;
      cmd.argument      = {arg_hi, arg_lo};
      cmd.resp_expected = (cmd_resp_type == resp_r48);
   end

   // Read decode, unmapped addresses read zero
   always_comb begin
      case (reg_address)
         addr_arg_lo:  reg_rd_data = {16'h0, arg_lo};
         addr_arg_hi:  reg_rd_data = {16'h0, arg_hi};
         addr_cmd:     reg_rd_data = {22'h0, cmd_resp_type, 2'b00, cmd_index};
         addr_resp_lo: reg_rd_data = {16'h0, resp_payload[15:0]};
         addr_resp_hi: reg_rd_data = {16'h0, resp_payload[31:16]};
         // Echoed index in 13:8, flags in 3:0
         addr_status:  reg_rd_data = {18'h0, resp_index, 4'h0,
                                      timeout, end_err, crc_err, busy};
         default:      reg_rd_data = 32'h0;
      endcase
   end

endmodule

/* hdl/sd_cmd_rx.sv */
////////////////////////////////////////////////////////////////////////////
// CMD receiver of the SD host
// Start bit wait with timeout, response shift, CRC7 and end bit checks,
// result strobe
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sd_cmd_rx (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 tx_done,
   input  logic                 resp_expected,
   input  logic                 cmd_in,
   output logic                 result_valid,
   output sd_cmd_pkg::sd_resp_t result
);

   import sd_cmd_pkg::*;

   typedef enum logic [1:0] {
      st_idle,
      st_wait,
      st_shift
   } rx_state_t;

   rx_state_t              state;
   logic [ncr_cnt_w-1:0]   wait_cnt;
   logic [frame_cnt_w-1:0] bit_cnt;
   logic [frame_bits-2:0]  shreg;
   logic [frame_bits-1:0]  frame;
   logic [crc_bits-1:0]    crc;
   logic                   crc_shift;
   logic                   start_seen;
   logic                   no_answer;
   logic                   last_bit;
   logic                   no_resp;

   assign no_resp    = (state == st_idle) && tx_done && !resp_expected;
   assign start_seen = (state == st_wait) && !cmd_in;
   assign no_answer  = (state == st_wait) && cmd_in &&
                       (wait_cnt == ncr_cnt_w'(ncr_max - 1));
   assign last_bit   = (state == st_shift) &&
                       (bit_cnt == frame_cnt_w'(frame_bits - 1));

   // Full response, valid while the end bit is on the line
   assign frame = {shreg, cmd_in};

   // Start bit counts as frame bit 0 of the CRC span
   assign crc_shift = start_seen ||
                      ((state == st_shift) && (bit_cnt < frame_cnt_w'(head_bits)));

   ////////////////////////////////////////////////////////////////////////
   // Receive FSM
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state        <= st_idle;
         wait_cnt     <= '0;
         bit_cnt      <= '0;
         result_valid <= 1'b0;
      end else begin
         result_valid <= 1'b0;
         case (state)
            st_idle: begin
               if (tx_done && resp_expected) begin
                  state    <= st_wait;
                  wait_cnt <= '0;
               end else if (no_resp) begin
                  result_valid <= 1'b1;
               end
            end
            st_wait: begin
               if (start_seen) begin
                  state   <= st_shift;
                  bit_cnt <= frame_cnt_w'(1);
               end else if (no_answer) begin
                  state        <= st_idle;
                  result_valid <= 1'b1;
               end else begin
                  wait_cnt <= wait_cnt + 1'b1;
               end
            end
            st_shift: begin
               if (last_bit) begin
                  state        <= st_idle;
                  result_valid <= 1'b1;
               end else begin
                  bit_cnt <= bit_cnt + 1'b1;
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // Shifting while waiting is harmless, idle ones fall off the top
   always_ff @(posedge clk) begin
      if (state != st_idle) begin
         shreg <= {shreg[frame_bits-3:0], cmd_in};
      end
      if (no_resp || no_answer) begin
         result         <= '0;
         result.timeout <= no_answer;
      end else if (last_bit) begin
         // 47 start, 46 transmission, 45:40 index, 39:8 payload, 7:1 CRC, 0 end
         result.index   <= frame[45:40];
         result.payload <= frame[39:8];
         result.crc_err <= (frame[7:1] != crc);
         result.end_err <= !frame[0];
         result.timeout <= 1'b0;
      end
   end

   sd_cmd_crc7 u_crc7 (
      .clk      (clk),
      .rst_n    (rst_n),
      .clear    (tx_done),
      .shift_en (crc_shift),
      .bit_in   (cmd_in),
      .crc      (crc)
   );

endmodule

/* hdl/sd_cmd_tx.sv */
////////////////////////////////////////////////////////////////////////////
// CMD transmitter of the SD host
// Frame head shift register, bit counter and CRC7 tail
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sd_cmd_tx (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                launch,
   input  sd_cmd_pkg::sd_cmd_t cmd,
   output logic                cmd_out,
   output logic                cmd_oe,
   output logic                tx_done,
   output logic                resp_expected
);

   import sd_cmd_pkg::*;

   logic [head_bits-1:0]   head;
   logic [frame_cnt_w-1:0] bit_cnt;
   logic [crc_bits-1:0]    crc;
   logic                   crc_shift;
   logic                   last_bit;

   assign last_bit = cmd_oe && (bit_cnt == frame_cnt_w'(frame_bits - 1));

   ////////////////////////////////////////////////////////////////////////
   // Frame sequencing
   ////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cmd_oe        <= 1'b0;
         tx_done       <= 1'b0;
         bit_cnt       <= '0;
         resp_expected <= 1'b0;
      end else begin
         tx_done <= 1'b0;
         if (launch) begin
            // Drive the line from the next cycle on
            cmd_oe        <= 1'b1;
            bit_cnt       <= '0;
            resp_expected <= cmd.resp_expected;
         end else if (last_bit) begin
            cmd_oe  <= 1'b0;
            tx_done <= 1'b1;
         end else if (cmd_oe) begin
            bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   // Start 0, transmission 1, index, argument; MSB leaves first
   always_ff @(posedge clk) begin
      if (launch) begin
         head <= {1'b0, 1'b1, cmd.index, cmd.argument};
      end else if (cmd_oe) begin
         head <= {head[head_bits-2:0], 1'b0};
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // Line driver
   ////////////////////////////////////////////////////////////////////////

   // Head bits, then CRC from its register, then the end bit
   always_comb begin
      if (!cmd_oe) begin
         cmd_out = 1'b1;
      end else if (bit_cnt < frame_cnt_w'(head_bits)) begin
         cmd_out = head[head_bits-1];
      end else if (!last_bit) begin
         cmd_out = crc[crc_bits-1];
      end else begin
         cmd_out = 1'b1;
      end
   end

   // CRC takes every bit but the end bit
   // During the tail it is fed its own top bit and just shifts
   assign crc_shift = cmd_oe && !last_bit;

   sd_cmd_crc7 u_crc7 (
      .clk      (clk),
      .rst_n    (rst_n),
      .clear    (launch),
      .shift_en (crc_shift),
      .bit_in   (cmd_out),
      .crc      (crc)
   );

endmodule

/* sd_cmd_host.f */
hdl/sd_cmd_pkg.sv
hdl/sd_cmd_crc7.sv
hdl/sd_cmd_regs.sv
hdl/sd_cmd_tx.sv
hdl/sd_cmd_rx.sv
hdl/sd_cmd_host.sv
verification/sd_cmd_clkgen.sv
verification/sd_cmd_chk.sv
verification/sd_cmd_tb.sv

/* verification/sd_cmd_chk.sv */
////////////////////////////////////////////////////////////////////////////
// CMD line protocol checks on the host top level
// Reset state, burst length, frame edges and completion pulse width
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sd_cmd_chk (
   input logic clk,
   input logic rst_n,
   input logic cmd_oe,
   input logic cmd_out,
   input logic cmd_done
);

   import sd_cmd_pkg::*;

   // Number of cycles the line has been driven in the current burst
   logic [5:0] oe_len;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         oe_len <= '0;
      end else if (cmd_oe) begin
         oe_len <= oe_len + 6'd1;
      end else begin
         oe_len <= '0;
      end
   end

   ////////////////////////////////////////////////////////////////////////
   // Reset behavior
   ////////////////////////////////////////////////////////////////////////

   oe_in_reset: assert property (@(posedge clk) !rst_n |-> !cmd_oe)
      else $error("cmd_oe high while reset is asserted");

   idle_after_reset: assert property (@(posedge clk)
      $rose(rst_n) |-> (!cmd_oe && cmd_out && !cmd_done))
      else $error("CMD line not idle when reset is released");

   ////////////////////////////////////////////////////////////////////////
   // Frame on the CMD line
   ////////////////////////////////////////////////////////////////////////

   // Never longer than a frame, and exactly a frame when it ends
   oe_not_too_long: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_oe |-> (oe_len < 6'(frame_bits)))
      else $error("cmd_oe burst longer than one frame");

   oe_exact_len: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(cmd_oe) |-> (oe_len == 6'(frame_bits)))
      else $error("cmd_oe burst shorter than one frame");

   start_bit_low: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(cmd_oe) |-> !cmd_out)
      else $error("frame does not open with start bit 0");

   end_bit_high: assert property (@(posedge clk) disable iff (!rst_n)
      (cmd_oe && (oe_len == 6'(frame_bits - 1))) |-> cmd_out)
      else $error("frame does not close with end bit 1");

   // Completion is a single cycle strobe
   done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_done |=> !cmd_done)
      else $error("cmd_done held for more than one cycle");

endmodule

bind sd_cmd_host sd_cmd_chk u_chk (
   .clk      (clk),
   .rst_n    (rst_n),
   .cmd_oe   (cmd_oe),
   .cmd_out  (cmd_out),
   .cmd_done (cmd_done)
);

/* verification/sd_cmd_clkgen.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench clock and reset
// 40 ns clock, active low reset held for three cycles
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sd_cmd_clkgen (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = ~clk;
      end
   end

   // Release on a falling edge, away from the sampling edge
   initial begin
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

/* verification/sd_cmd_tb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench top of the SD command path
// Card model, register access, frame capture, scenarios and cycle limit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sd_cmd_tb;

   import sd_cmd_pkg::*;

   localparam int cycle_limit = 2000;

   logic        clk;
   logic        rst_n;
   logic [11:0] reg_address;
   logic [31:0] reg_wr_data;
   logic        reg_wr_en;
   logic [31:0] reg_rd_data;
   logic        cmd_in;
   logic        cmd_out;
   logic        cmd_oe;
   logic        cmd_done;
   int          cycle_cnt;

   sd_cmd_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

   sd_cmd_host DUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .reg_address (reg_address),
      .reg_wr_data (reg_wr_data),
      .reg_wr_en   (reg_wr_en),
      .reg_rd_data (reg_rd_data),
      .cmd_in      (cmd_in),
      .cmd_out     (cmd_out),
      .cmd_oe      (cmd_oe),
      .cmd_done    (cmd_done)
   );

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
      assert (got === expected) else fail_now($sformatf(
         "MISMATCH at %0t: %s is %h, expected %h", $time, what, got, expected));
   endtask

   task automatic check_bit(input string what, input logic got, input logic expected);
      assert (got === expected) else fail_now($sformatf(
         "MISMATCH at %0t: %s is %b, expected %b", $time, what, got, expected));
   endtask

   // CRC7 as the remainder of head * x^7 divided by x^7 + x^3 + 1
   function automatic logic [6:0] crc7_of(input logic [39:0] head);
      logic [46:0] rem;
      rem = {head, 7'h0};
      for (int i = 46; i >= 7; i--) begin
         if (rem[i]) begin
            rem[i -: 8] = rem[i -: 8] ^ {1'b1, crc7_poly};
         end
      end
      return rem[6:0];
   endfunction

   ////////////////////////////////////////////////////////////////////////
   // Register port and CMD line tasks
   ////////////////////////////////////////////////////////////////////////

   // Every task here is entered just after a falling edge
   task automatic reg_write(input logic [11:0] addr, input logic [31:0] data);
      reg_address = addr;
      reg_wr_data = data;
      reg_wr_en   = 1'b1;
      @(negedge clk);
      reg_wr_en   = 1'b0;
   endtask

   // Combinational read sampled a quarter period after the address
   task automatic reg_read(input logic [11:0] addr, output logic [31:0] data);
      reg_address = addr;
      #10;
      data = reg_rd_data;
      @(negedge clk);
   endtask

   task automatic issue_command(input logic [5:0] idx, input logic [31:0] arg,
                                input logic [1:0] rtype);
      reg_write(addr_arg_lo, {16'h0, arg[15:0]});
      reg_write(addr_arg_hi, {16'h0, arg[31:16]});
      reg_write(addr_cmd, {22'h0, rtype, 2'b00, idx});
   endtask

   // Line must be idle now and carry the frame from the next falling edge
   task automatic capture_frame(input logic [5:0] idx, input logic [31:0] arg);
      logic [39:0] head;
      logic [47:0] got;
      logic [47:0] expected;
      head     = {1'b0, 1'b1, idx, arg};
      expected = {head, crc7_of(head), 1'b1};
      check_bit("cmd_oe one cycle after command write", cmd_oe, 1'b0);
      @(negedge clk);
      for (int i = 47; i >= 0; i--) begin
         check_bit("cmd_oe inside frame", cmd_oe, 1'b1);
         got[i] = cmd_out;
         @(negedge clk);
      end
      check_bit("cmd_oe after frame", cmd_oe, 1'b0);
      assert (got === expected) else fail_now($sformatf(
         "MISMATCH at %0t: command frame is %h, expected %h", $time, got, expected));
   endtask

   // Card answer after a random gap with the CRC bits in flip inverted
   task automatic card_answer(input logic [5:0] idx, input logic [31:0] payload,
                              input logic [6:0] flip);
      int unsigned gap;
      logic [39:0] head;
      logic [47:0] frame;
      gap   = 1 + ($urandom % 50);
      head  = {1'b0, 1'b0, idx, payload};
      frame = {head, crc7_of(head) ^ flip, 1'b1};
      repeat (gap) @(negedge clk);
      for (int i = 47; i >= 0; i--) begin
         cmd_in = frame[i];
         @(negedge clk);
      end
      cmd_in = 1'b1;
   endtask

   task automatic wait_done();
      while (cmd_done !== 1'b1) begin
         @(negedge clk);
      end
   endtask

   task automatic check_status(input logic [3:0] flags);
      logic [31:0] word;
      reg_read(addr_status, word);
      check_value("status flags", {28'h0, word[3:0]}, {28'h0, flags});
   endtask

   ////////////////////////////////////////////////////////////////////////
   // Scenarios
   ////////////////////////////////////////////////////////////////////////

   // Response command that the card answers only when told to
   task automatic run_response_command(input logic answer, input logic [6:0] flip,
                                       input logic [3:0] flags);
      logic [5:0]  idx;
      logic [31:0] arg;
      logic [31:0] payload;
      logic [31:0] word;
      idx     = 6'($urandom);
      arg     = $urandom;
      payload = $urandom;
      issue_command(idx, arg, resp_r48);
      capture_frame(idx, arg);
      if (answer) begin
         card_answer(idx, payload, flip);
      end
      wait_done();
      check_status(flags);
      if (answer) begin
         reg_read(addr_resp_lo, word);
         check_value("response low half", word, {16'h0, payload[15:0]});
         reg_read(addr_resp_hi, word);
         check_value("response high half", word, {16'h0, payload[31:16]});
         // Card echoes the command index in its response
         reg_read(addr_status, word);
         check_value("echoed response index", {26'h0, word[13:8]}, {26'h0, idx});
      end
   endtask

   // Second command word lands in the middle of the first frame
   task automatic run_busy_write();
      logic [31:0] word;
      issue_command(6'h11, 32'h1234_5678, 2'd0);
      fork
         capture_frame(6'h11, 32'h1234_5678);
         begin
            repeat (5) @(negedge clk);
            reg_write(addr_cmd, {22'h0, 2'd0, 2'b00, 6'h2A});
         end
      join
      wait_done();
      check_status(4'h0);
      reg_read(addr_cmd, word);
      check_value("command word after busy write", {26'h0, word[5:0]}, 32'h11);
      repeat (10) begin
         check_bit("cmd_oe after ignored write", cmd_oe, 1'b0);
         @(negedge clk);
      end
   endtask

   // Run length guard
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         fail_now("Timeout: cycle limit reached before the scenarios finished");
      end
   end

   initial begin
      cycle_cnt   = 0;
      reg_address = '0;
      reg_wr_data = '0;
      reg_wr_en   = 1'b0;
      cmd_in      = 1'b1;
      void'($urandom(32'h646c_de3b));
      @(posedge rst_n);
      @(negedge clk);
      check_bit("cmd_out after reset", cmd_out, 1'b1);
      check_bit("cmd_done after reset", cmd_done, 1'b0);
      // Frame and good response
      run_response_command(1'b1, 7'h00, 4'h0);
      // No response expected
      issue_command(6'h00, 32'h0000_0000, 2'd0);
      capture_frame(6'h00, 32'h0000_0000);
      wait_done();
      check_status(4'h0);
      // Second good response with its own gap
      run_response_command(1'b1, 7'h00, 4'h0);
      // One CRC bit flipped by the card
      run_response_command(1'b1, 7'b1 << ($urandom % 7), 4'h2);
      // Card stays silent
      run_response_command(1'b0, 7'h00, 4'h8);
      run_busy_write();
      $display("All checks passed");
      $finish;
   end

endmodule
